// File: compile.f
+incdir+verilog
verilog/usbRxPkg.sv
verilog/usbCrcIf.sv
verilog/crc5Unit.sv
verilog/crc16Unit.sv
verilog/rxByteProcessor.sv
verilog/usbRxProcessor.sv
tests/usbRx_asserts.sv
tests/tbUsbRx.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tbUsbRx \
  -Mdir obj_dir -o simUsbRx

# Keep running past assertion errors so the testbench can report
./obj_dir/simUsbRx +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

// File: tests/tbUsbRx.sv
`timescale 1ns/1ps
`include "usbRx_consts.svh"

module tbUsbRx;
  import usbRxPkg::*;

  logic        clk;
  logic        rst;
  logic [7:0]  byteIn;
  logic [7:0]  ctrlIn;
  logic        byteInWEn;
  logic        byteRdy;
  logic [7:0]  dataOut;
  logic [7:0]  ctrlOut;
  logic        dataOutWEn;
  logic [15:0] outQ[$];  // {ctrl, byte} as seen on the output
  logic [15:0] expQ[$];
  logic [7:0]  payQ[$];  // Bytes after the PID
  logic [31:0] rngState = 32'h2ce0_0c0d;
  int          errCnt = 0;
  int          errMark = 0;
  int          testPass = 0;
  int          testFail = 0;

  usbRxProcessor uut (
    .clk        (clk),
    .rst        (rst),
    .byteIn     (byteIn),
    .ctrlIn     (ctrlIn),
    .byteInWEn  (byteInWEn),
    .byteRdy    (byteRdy),
    .dataOut    (dataOut),
    .ctrlOut    (ctrlOut),
    .dataOutWEn (dataOutWEn)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    if (dataOutWEn)
    begin
      outQ.push_back({ctrlOut, dataOut});
    end
  end

  function automatic logic [7:0] randByte();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState[23:16];
  endfunction

  // Reflected USB CRC16 returned inverted
  function automatic logic [15:0] crc16Ref();
    logic [15:0] c;
    logic        fb;
    c = 16'hFFFF;
    foreach (payQ[i])
    begin
      for (int b = 0; b < 8; b++)
      begin
        fb = c[0] ^ payQ[i][b];
        c  = (c >> 1) ^ (fb ? 16'hA001 : 16'h0000);
      end
    end
    return ~c;
  endfunction

  function automatic logic [4:0] crc5Ref(input logic [10:0] v);
    logic [4:0] c;
    logic       fb;
    c = 5'h1F;
    for (int b = 0; b < 11; b++)
    begin
      fb = c[0] ^ v[b];
      c  = (c >> 1) ^ (fb ? 5'h14 : 5'h00);
    end
    return ~c;
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic sendByte(input logic [7:0] ctrl, input logic [7:0] value);
    int waitCnt;
    waitCnt = 0;
    while (!byteRdy && waitCnt < 50)
    begin
      tick();
      waitCnt++;
    end
    if (!byteRdy)
    begin
      errCnt++;
      $display("Timeout: byteRdy stayed low for 50 cycles");
    end
    else
    begin
      byteIn    = value;
      ctrlIn    = ctrl;
      byteInWEn = 1'b1;
      tick();
      byteInWEn = 1'b0;
    end
  endtask

  task automatic sendPacket(input logic [7:0] pid, input logic [7:0] endCtrl);
    sendByte(dataStart, 8'h00);
    sendByte(dataStream, `SYNC_BYTE);
    sendByte(dataStream, pid);
    foreach (payQ[i])
    begin
      sendByte(dataStream, payQ[i]);
    end
    sendByte(endCtrl, 8'h00);
  endtask

  task automatic addExpected(input logic [7:0] ctrl, input logic [7:0] value);
    expQ.push_back({ctrl, value});
  endtask

  task automatic expectOut(input string name, input logic [15:0] exp);
    int          waitCnt;
    logic [15:0] got;
    waitCnt = 0;
    while (outQ.size() == 0 && waitCnt < 50)
    begin
      tick();
      waitCnt++;
    end
    assert (outQ.size() != 0)
    else
    begin
      errCnt++;
      $display("%s: output %h never appeared within 50 cycles", name, exp);
    end
    if (outQ.size() != 0)
    begin
      got = outQ.pop_front();
      assert (got == exp)
      else
      begin
        errCnt++;
        $display("** Error %s: expected %h, actual %h", name, exp, got);
      end
    end
  endtask

  task automatic finishTest(input string name);
    int waitCnt;
    while (expQ.size() != 0)
    begin
      expectOut(name, expQ.pop_front());
    end
    waitCnt = 0;
    while (!byteRdy && waitCnt < 50)
    begin
      tick();
      waitCnt++;
    end
    assert (byteRdy)
    else
    begin
      errCnt++;
      $display("%s: byteRdy did not return within 50 cycles", name);
    end
    repeat (4) tick();
    assert (outQ.size() == 0)
    else
    begin
      errCnt++;
      $display("%s: %0d unexpected output bytes", name, outQ.size());
      outQ.delete();
    end
    if (errCnt == errMark)
    begin
      testPass++;
      $display("test %s: ok", name);
    end
    else
    begin
      testFail++;
      $display("test %s: failed with %0d errors", name, errCnt - errMark);
    end
    errMark = errCnt;
  endtask

  task automatic runHandshake(input string name, input logic [7:0] pid,
                              input logic [7:0] status, input logic extra);
    payQ.delete();
    if (extra)
    begin
      payQ.push_back(8'hA5);  // Anything but stop is an overflow
    end
    sendPacket(pid, dataStop);
    addExpected(pktStart, pid);
    addExpected(pktStop, extra ? (status | 8'h04) : status);
    finishTest(name);
  endtask

  task automatic runData(input string name, input logic [7:0] pid, input int len,
                         input logic corrupt, input logic [7:0] endCtrl);
    logic [15:0] crc;
    payQ.delete();
    for (int i = 0; i < len; i++)
    begin
      payQ.push_back(randByte());
    end
    crc = crc16Ref();
    payQ.push_back(crc[7:0]);
    payQ.push_back(crc[15:8]);
    if (corrupt)
    begin
      payQ[1] = payQ[1] ^ 8'h10;
    end
    if (endCtrl == dataBitStuffError)
    begin
      payQ = payQ[0:2];  // Cut short mid-packet
    end
    sendPacket(pid, endCtrl);
    addExpected(pktStart, pid);
    foreach (payQ[i])
    begin
      addExpected(pktStream, payQ[i]);
    end
    addExpected(pktStop, {1'b0, pid[3], 4'b0000, endCtrl == dataBitStuffError, corrupt});
    finishTest(name);
  endtask

  task automatic runToken(input string name, input logic [7:0] pid,
                          input logic [10:0] addrEp, input logic extra);
    logic [15:0] tok;
    tok = {crc5Ref(addrEp), addrEp};
    payQ.delete();
    payQ.push_back(tok[7:0]);
    payQ.push_back(tok[15:8]);
    if (extra)
    begin
      payQ.push_back(randByte());
    end
    sendPacket(pid, dataStop);
    addExpected(pktStart, pid);
    addExpected(pktStream, tok[7:0]);
    addExpected(pktStream, tok[15:8]);
    addExpected(pktStop, extra ? 8'h04 : 8'h00);
    finishTest(name);
  endtask

  initial
  begin
    rst       = 1'b1;
    byteIn    = 8'h00;
    ctrlIn    = 8'h00;
    byteInWEn = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (3) tick();  // Past the init cycle

    runHandshake("ack", 8'hD2, 8'h20, 1'b0);
    runHandshake("nak", 8'h5A, 8'h08, 1'b0);
    runHandshake("stall", 8'h1E, 8'h10, 1'b0);
    runHandshake("ackExtraByte", 8'hD2, 8'h20, 1'b1);
    runData("data0", 8'hC3, 6, 1'b0, dataStop);
    runData("data1", 8'h4B, 9, 1'b0, dataStop);
    runData("dataBadCrc", 8'hC3, 5, 1'b1, dataStop);
    runToken("tokenOut", 8'hE1, 11'h1FA, 1'b0);
    runToken("tokenIn", 8'h69, 11'h305, 1'b0);
    runToken("tokenOverflow", 8'h2D, 11'h0C2, 1'b1);
    runData("bitStuff", 8'h4B, 4, 1'b0, dataBitStuffError);

    // Wrong SYNC, bad PID, then bytes with no start
    sendByte(dataStart, 8'h00);
    sendByte(dataStream, 8'h81);
    sendByte(dataStream, 8'hD2);
    sendByte(dataStop, 8'h00);
    sendByte(dataStart, 8'h00);
    sendByte(dataStream, `SYNC_BYTE);
    sendByte(dataStream, 8'hC4);
    sendByte(dataStop, 8'h00);
    sendByte(dataStream, `SYNC_BYTE);
    sendByte(dataStream, 8'h5A);
    sendByte(dataStop, 8'h00);
    runData("junkThenData", 8'h4B, 3, 1'b0, dataStop);

    $display("tests: %0d passed, %0d failed, %0d protocol assertion failures",
             testPass, testFail, uut.proc.chk.failCnt);
    if (testFail == 0 && uut.proc.chk.failCnt == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: tests/usbRx_asserts.sv
`timescale 1ns/1ps

module usbRxAsserts (
  input logic clk,
  input logic rst,
  input logic byteInWEn,
  input logic byteRdy,
  input logic dataOutWEn,
  input logic crc5En,
  input logic crc5Rdy,
  input logic crc16En,
  input logic crc16Rdy
);

  int failCnt = 0;

  weOnePulse: assert property (@(posedge clk) disable iff (rst)
    dataOutWEn |=> !dataOutWEn)
  else
  begin
    failCnt++;
    $error("dataOutWEn high for more than one cycle");
  end

  rdyDropsOnStrobe: assert property (@(posedge clk) disable iff (rst)
    (byteInWEn && byteRdy) |=> !byteRdy)
  else
  begin
    failCnt++;
    $error("byteRdy still high after an accepted strobe");
  end

  crc5EnWhenRdy: assert property (@(posedge clk) disable iff (rst)
    crc5En |-> crc5Rdy)
  else
  begin
    failCnt++;
    $error("crc5En given while the CRC5 unit was busy");
  end

  crc16EnWhenRdy: assert property (@(posedge clk) disable iff (rst)
    crc16En |-> crc16Rdy)
  else
  begin
    failCnt++;
    $error("crc16En given while the CRC16 unit was busy");
  end

  // Low for exactly eight shifts
  crc5Busy8: assert property (@(posedge clk) disable iff (rst)
    $rose(crc5Rdy) |-> (!$past(crc5Rdy, 8) && $past(crc5Rdy, 9)))
  else
  begin
    failCnt++;
    $error("crc5Rdy low for other than 8 cycles");
  end

  crc16Busy8: assert property (@(posedge clk) disable iff (rst)
    $rose(crc16Rdy) |-> (!$past(crc16Rdy, 8) && $past(crc16Rdy, 9)))
  else
  begin
    failCnt++;
    $error("crc16Rdy low for other than 8 cycles");
  end

endmodule

bind rxByteProcessor usbRxAsserts chk (
  .clk        (clk),
  .rst        (rst),
  .byteInWEn  (byteInWEn),
  .byteRdy    (byteRdy),
  .dataOutWEn (dataOutWEn),
  .crc5En     (crc.crc5En),
  .crc5Rdy    (crc.crc5Rdy),
  .crc16En    (crc.crc16En),
  .crc16Rdy   (crc.crc16Rdy)
);

// File: verilog/usbRxProcessor.sv
`timescale 1ns/1ps

module usbRxProcessor (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] byteIn,
  input  logic [7:0] ctrlIn,
  input  logic       byteInWEn,
  output logic       byteRdy,
  output logic [7:0] dataOut,
  output logic [7:0] ctrlOut,
  output logic       dataOutWEn
);
  import usbRxPkg::*;

  rxCtrlIn_e  ctrlInCode;
  rxCtrlOut_e ctrlOutCode;

  usbCrcIf crcBus ();

  // Plain byte codes at the boundary
  assign ctrlInCode = rxCtrlIn_e'(ctrlIn);
  assign ctrlOut    = ctrlOutCode;

  rxByteProcessor proc (
    .clk        (clk),
    .rst        (rst),
    .byteIn     (byteIn),
    .ctrlIn     (ctrlInCode),
    .byteInWEn  (byteInWEn),
    .byteRdy    (byteRdy),
    .dataOut    (dataOut),
    .ctrlOut    (ctrlOutCode),
    .dataOutWEn (dataOutWEn),
    .crc        (crcBus.proc)
  );

  crc5Unit crc5 (
    .clk (clk),
    .rst (rst),
    .crc (crcBus.crc5)
  );

  crc16Unit crc16 (
    .clk (clk),
    .rst (rst),
    .crc (crcBus.crc16)
  );

endmodule

// File: verilog/rxByteProcessor.sv
`timescale 1ns/1ps
`include "usbRx_consts.svh"

module rxByteProcessor (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [7:0]           byteIn,
  input  usbRxPkg::rxCtrlIn_e  ctrlIn,
  input  logic                 byteInWEn,
  output logic                 byteRdy,
  output logic [7:0]           dataOut,
  output usbRxPkg::rxCtrlOut_e ctrlOut,
  output logic                 dataOutWEn,
  usbCrcIf.proc                crc
);
  import usbRxPkg::*;

  procSt_e                 state;
  procSt_e                 stateNxt;
  byteSt_e                 byteSt;
  byteSt_e                 byteStNxt;
  logic [7:0]              rxByte;
  logic [7:0]              rxByteNxt;
  rxCtrlIn_e               rxCtrl;
  rxCtrlIn_e               rxCtrlNxt;
  logic [statFlagBits-1:0] flags;
  logic [statFlagBits-1:0] flagsNxt;
  logic [9:0]              byteCnt;
  logic [9:0]              byteCntNxt;
  logic                    byteRdyNxt;
  logic [7:0]              dataOutNxt;
  rxCtrlOut_e              ctrlOutNxt;
  logic                    dataOutWEnNxt;
  logic                    rstCrcNxt;
  logic [7:0]              crcDataNxt;
  logic                    crc5EnNxt;
  logic                    crc16EnNxt;
  logic                    emitStatus;
  logic                    isToken;
  logic                    crcBad;

  assign isToken = (state == stTokenChkStrm);
  assign crcBad  = isToken ? (crc.crc5Result != `CRC5_RESIDUE)
                           : (crc.crc16Result != `CRC16_RESIDUE);

  always_comb
  begin
    stateNxt      = state;
    byteStNxt     = byteSt;
    rxByteNxt     = rxByte;
    rxCtrlNxt     = rxCtrl;
    flagsNxt      = flags;
    byteCntNxt    = byteCnt;
    byteRdyNxt    = byteRdy;
    dataOutNxt    = dataOut;
    ctrlOutNxt    = ctrlOut;
    crcDataNxt    = crc.crcData;
    dataOutWEnNxt = 1'b0;  // Pulses default low
    rstCrcNxt     = 1'b0;
    crc5EnNxt     = 1'b0;
    crc16EnNxt    = 1'b0;
    emitStatus    = 1'b0;

    case (state)
      stInit:
      begin
        byteStNxt  = idleByte;
        flagsNxt   = '0;
        byteCntNxt = '0;
        byteRdyNxt = 1'b1;
        stateNxt   = stWaitByte;
      end

      stWaitByte:
      begin
        if (byteInWEn)
        begin
          rxByteNxt  = byteIn;
          rxCtrlNxt  = ctrlIn;
          byteRdyNxt = 1'b0;
          stateNxt   = stChk;
        end
      end

      // Dispatch on packet phase
      stChk:
      begin
        case (byteSt)
          idleByte:  stateNxt = stIdleChkStart;
          checkSync: stateNxt = stChkSync;
          checkPid:  stateNxt = stChkPid;
          tokenByte: stateNxt = stTokenWaitCrc;
          dataByte:  stateNxt = stDataWaitCrc;
          hsByte:    stateNxt = stHsChk;
          default:   stateNxt = stInit;
        endcase
      end

      stIdleChkStart:
      begin
        if (rxCtrl == dataStart)
        begin
          byteStNxt = checkSync;
        end
        byteRdyNxt = 1'b1;
        stateNxt   = stWaitByte;
      end

      stChkSync:
      begin
        byteStNxt  = (rxByte == `SYNC_BYTE) ? checkPid : idleByte;
        byteRdyNxt = 1'b1;
        stateNxt   = stWaitByte;
      end

      stChkPid:
      begin
        if ((rxByte[7:4] ^ rxByte[3:0]) == 4'hF)
        begin
          flagsNxt      = '0;
          byteCntNxt    = '0;
          dataOutNxt    = rxByte;
          ctrlOutNxt    = pktStart;
          dataOutWEnNxt = 1'b1;
          rstCrcNxt     = 1'b1;
          stateNxt      = stPidFirstByte;
        end
        else
        begin
          byteStNxt  = idleByte;  // Bad PID, drop silently
          byteRdyNxt = 1'b1;
          stateNxt   = stWaitByte;
        end
      end

      stPidFirstByte:
      begin
        case (pidType_e'(rxByte[1:0]))
          token:
          begin
            byteStNxt = tokenByte;
          end
          handshake:
          begin
            case (rxByte[3:2])
              2'b00:   flagsNxt[statAck] = 1'b1;
              2'b10:   flagsNxt[statNak] = 1'b1;
              2'b11:   flagsNxt[statStall] = 1'b1;
              default: flagsNxt[statAck] = 1'b0;  // NYET, no flag
            endcase
            byteStNxt = hsByte;
          end
          data:
          begin
            flagsNxt[statDataSeq] = rxByte[3];
            byteStNxt = dataByte;
          end
          default:
          begin
            byteStNxt = idleByte;
          end
        endcase
        byteRdyNxt = 1'b1;
        stateNxt   = stWaitByte;
      end

      // Anything but stop after a handshake PID is an overflow
      stHsChk:
      begin
        if (rxCtrl != dataStop)
        begin
          flagsNxt[statOverflow] = 1'b1;
        end
        emitStatus    = 1'b1;
        ctrlOutNxt    = pktStop;
        dataOutWEnNxt = 1'b1;
        byteStNxt     = idleByte;
        stateNxt      = stHsFin;
      end

      stTokenWaitCrc:
      begin
        if (crc.crc5Rdy)
        begin
          stateNxt = stTokenChkStrm;
        end
      end

      stDataWaitCrc:
      begin
        if (crc.crc16Rdy)
        begin
          stateNxt = stDataChkStrm;
        end
      end

      stTokenChkStrm, stDataChkStrm:
      begin
        byteCntNxt = byteCnt + 10'd1;
        case (rxCtrl)
          dataStop:
          begin
            flagsNxt[statCrcError] = crcBad;
            emitStatus = 1'b1;
          end
          dataBitStuffError:
          begin
            flagsNxt[statBitStuff] = 1'b1;
            emitStatus = 1'b1;
          end
          dataStream:
          begin
            if (isToken && (byteCnt >= `TOKEN_MAX_BYTES))
            begin
              flagsNxt[statOverflow] = 1'b1;
              emitStatus = 1'b1;
            end
            else
            begin
              dataOutNxt    = rxByte;
              ctrlOutNxt    = pktStream;
              dataOutWEnNxt = 1'b1;
              crcDataNxt    = rxByte;
              crc5EnNxt     = isToken;
              crc16EnNxt    = !isToken;
            end
          end
          default:
          begin
            byteStNxt = idleByte;  // Unexpected start, abandon packet
          end
        endcase
        if (emitStatus)
        begin
          ctrlOutNxt    = pktStop;
          dataOutWEnNxt = 1'b1;
          byteStNxt     = idleByte;
        end
        stateNxt = isToken ? stTokenFin : stDataFin;
      end

      stHsFin, stTokenFin, stDataFin:
      begin
        byteRdyNxt = 1'b1;
        stateNxt   = stWaitByte;
      end

      default:
      begin
        stateNxt = stInit;
      end
    endcase

    // Status carries the flags updated this cycle
    if (emitStatus)
    begin
      dataOutNxt = {1'b0, flagsNxt};
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state       <= stInit;
      byteSt      <= idleByte;
      flags       <= '0;
      byteCnt     <= '0;
      byteRdy     <= 1'b1;
      dataOutWEn  <= 1'b0;
      crc.rstCrc  <= 1'b0;
      crc.crc5En  <= 1'b0;
      crc.crc16En <= 1'b0;
    end
    else
    begin
      state       <= stateNxt;
      byteSt      <= byteStNxt;
      flags       <= flagsNxt;
      byteCnt     <= byteCntNxt;
      byteRdy     <= byteRdyNxt;
      dataOutWEn  <= dataOutWEnNxt;
      crc.rstCrc  <= rstCrcNxt;
      crc.crc5En  <= crc5EnNxt;
      crc.crc16En <= crc16EnNxt;
    end
  end

  always_ff @(posedge clk)
  begin
    rxByte      <= rxByteNxt;
    rxCtrl      <= rxCtrlNxt;
    dataOut     <= dataOutNxt;
    ctrlOut     <= ctrlOutNxt;
    crc.crcData <= crcDataNxt;
  end

endmodule

// File: verilog/crc16Unit.sv
`timescale 1ns/1ps

module crc16Unit (
  input logic    clk,
  input logic    rst,
  usbCrcIf.crc16 crc
);

  logic [15:0] crcReg;
  logic [7:0]  dataSr;
  logic [2:0]  bitCnt;
  logic        fb;

  // x^16+x^15+x^2+1 reflected is 0xA001
  assign fb = crcReg[0] ^ dataSr[0];
  assign crc.crc16Result = crcReg;

  always_ff @(posedge clk)
  begin
    if (rst || crc.rstCrc)
    begin
      crcReg       <= 16'hFFFF;
      bitCnt       <= 3'd0;
      crc.crc16Rdy <= 1'b1;
    end
    else if (crc.crc16Rdy)
    begin
      if (crc.crc16En)
      begin
        bitCnt       <= 3'd0;
        crc.crc16Rdy <= 1'b0;
      end
    end
    else
    begin
      crcReg <= {1'b0, crcReg[15:1]} ^ (fb ? 16'hA001 : 16'h0000);
      bitCnt <= bitCnt + 3'd1;
      if (bitCnt == 3'd7)
      begin
        crc.crc16Rdy <= 1'b1;
      end
    end
  end

  // Byte shifts out LSB first
  always_ff @(posedge clk)
  begin
    if (crc.crc16Rdy && crc.crc16En)
    begin
      dataSr <= crc.crcData;
    end
    else if (!crc.crc16Rdy)
    begin
      dataSr <= {1'b0, dataSr[7:1]};
    end
  end

endmodule

// File: verilog/crc5Unit.sv
`timescale 1ns/1ps

module crc5Unit (
  input logic   clk,
  input logic   rst,
  usbCrcIf.crc5 crc
);

  logic [4:0] crcReg;
  logic [7:0] dataSr;
  logic [2:0] bitCnt;
  logic       fb;

  // Reflected x^5+x^2+1, LSB first
  assign fb = crcReg[0] ^ dataSr[0];
  assign crc.crc5Result = crcReg;

  always_ff @(posedge clk)
  begin
    if (rst || crc.rstCrc)
    begin
      crcReg      <= 5'h1F;
      bitCnt      <= 3'd0;
      crc.crc5Rdy <= 1'b1;
    end
    else if (crc.crc5Rdy)
    begin
      if (crc.crc5En)
      begin
        bitCnt      <= 3'd0;
        crc.crc5Rdy <= 1'b0;
      end
    end
    else
    begin
      crcReg <= {1'b0, crcReg[4:1]} ^ (fb ? 5'h14 : 5'h00);
      bitCnt <= bitCnt + 3'd1;
      if (bitCnt == 3'd7)
      begin
        crc.crc5Rdy <= 1'b1;  // Eighth shift done
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (crc.crc5Rdy && crc.crc5En)
    begin
      dataSr <= crc.crcData;
    end
    else if (!crc.crc5Rdy)
    begin
      dataSr <= {1'b0, dataSr[7:1]};
    end
  end

endmodule

// File: verilog/usbCrcIf.sv
`timescale 1ns/1ps

interface usbCrcIf;
  logic        rstCrc;      // One-cycle reload to all ones
  logic [7:0]  crcData;
  logic        crc5En;
  logic        crc16En;
  logic [4:0]  crc5Result;
  logic        crc5Rdy;
  logic [15:0] crc16Result;
  logic        crc16Rdy;

  modport proc (
    output rstCrc, crcData, crc5En, crc16En,
    input  crc5Result, crc5Rdy, crc16Result, crc16Rdy
  );

  modport crc5 (
    input  rstCrc, crcData, crc5En,
    output crc5Result, crc5Rdy
  );

  modport crc16 (
    input  rstCrc, crcData, crc16En,
    output crc16Result, crc16Rdy
  );
endinterface

// File: verilog/usbRxPkg.sv
package usbRxPkg;

  typedef enum logic [7:0] {
    dataStart         = 8'h00,
    dataStream        = 8'h01,
    dataStop          = 8'h02,
    dataBitStuffError = 8'h03
  } rxCtrlIn_e;

  typedef enum logic [7:0] {
    pktStart  = 8'h00,
    pktStream = 8'h01,
    pktStop   = 8'h02
  } rxCtrlOut_e;

  // PID bits 1:0
  typedef enum logic [1:0] {
    special   = 2'b00,
    token     = 2'b01,
    handshake = 2'b10,
    data      = 2'b11
  } pidType_e;

  typedef enum logic [2:0] {
    idleByte,
    checkSync,
    checkPid,
    tokenByte,
    dataByte,
    hsByte
  } byteSt_e;

  typedef enum logic [3:0] {
    stChk,
    stInit,
    stWaitByte,
    stIdleChkStart,
    stChkSync,
    stChkPid,
    stPidFirstByte,
    stHsFin,
    stHsChk,
    stTokenChkStrm,
    stTokenFin,
    stDataFin,
    stDataChkStrm,
    stTokenWaitCrc,
    stDataWaitCrc
  } procSt_e;

  // Status byte layout, bit 7 always zero
  localparam int statFlagBits = 7;
  localparam int statCrcError = 0;
  localparam int statBitStuff = 1;
  localparam int statOverflow = 2;
  localparam int statNak      = 3;
  localparam int statStall    = 4;
  localparam int statAck      = 5;
  localparam int statDataSeq  = 6;

endpackage

// File: verilog/usbRx_consts.svh
`ifndef USBRX_CONSTS_SVH
`define USBRX_CONSTS_SVH

// Sync pattern as seen after the serial engine
`define SYNC_BYTE 8'h80

// Register contents after a good packet, received CRC included
`define CRC5_RESIDUE 5'h06
`define CRC16_RESIDUE 16'hB001

// Token payload after the PID is 11 address bits plus CRC5
`define TOKEN_MAX_BYTES 10'd2

`endif
